//--- rtl/core_pkg.sv
// RV32I core shared definitions
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Instruction field positions
    localparam int OPCODE_W   = 7;
    localparam int RD_LSB     = 7;
    localparam int FUNCT3_LSB = 12;
    localparam int RS1_LSB    = 15;
    localparam int RS2_LSB    = 20;
    localparam int SUB_BIT    = 30;

    typedef enum logic [OPCODE_W-1:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011
    } opcode_e;

    // funct3 codes of the supported ops
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    // ADDI x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

`default_nettype wire

//--- rtl/core_ifs.sv
// Core interfaces
`timescale 1ns/1ps
`default_nettype none

// Decoded control bundle for the instruction in decode
interface ctrl_if import core_pkg::*; ();

    alu_op_e alu_op;
    logic    alu_src_imm;
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
    logic    branch;

    modport ctrl (
        output alu_op, alu_src_imm, mem_read, mem_write, reg_write, mem_to_reg, branch
    );

    modport stage (
        input alu_op, alu_src_imm, mem_read, mem_write, reg_write, mem_to_reg, branch
    );

endinterface

// Branch redirect from execute back to fetch
interface redirect_if import core_pkg::*; ();

    logic  branch_ex;
    logic  equal_ex;
    word_t target;
    // One cycle high for a taken BEQ
    logic  flush;

    modport ex (output branch_ex, equal_ex, target);
    modport ctrl (input branch_ex, equal_ex, output flush);
    modport fetch (input target, flush);

endinterface

`default_nettype wire

//--- rtl/main_control.sv
// Main decoder and flush control
`timescale 1ns/1ps
`default_nettype none

module main_control
    import core_pkg::*;
(
    input  word_t    instr,
    ctrl_if.ctrl     ctrl,
    redirect_if.ctrl redir
);

    opcode_e    opcode;
    logic [2:0] funct3;

    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic sub);
        case (f3)
            F3_ADD:  alu_decode = sub ? ALU_SUB : ALU_ADD;
            F3_SLL:  alu_decode = ALU_SLL;
            F3_SLT:  alu_decode = ALU_SLT;
            F3_XOR:  alu_decode = ALU_XOR;
            F3_SRL:  alu_decode = ALU_SRL;
            F3_OR:   alu_decode = ALU_OR;
            F3_AND:  alu_decode = ALU_AND;
            default: alu_decode = ALU_ADD;
        endcase
    endfunction

    assign opcode = opcode_e'(instr[OPCODE_W-1:0]);
    assign funct3 = instr[FUNCT3_LSB +: 3];

    always_comb begin
        ctrl.alu_op      = ALU_ADD;
        ctrl.alu_src_imm = 1'b0;
        ctrl.mem_read    = 1'b0;
        ctrl.mem_write   = 1'b0;
        ctrl.reg_write   = 1'b0;
        ctrl.mem_to_reg  = 1'b0;
        ctrl.branch      = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.alu_op    = alu_decode(funct3, instr[SUB_BIT]);
                ctrl.reg_write = 1'b1;
            end
            OPC_OP_IMM: begin
                // No immediate subtract in RV32I
                ctrl.alu_op      = alu_decode(funct3, 1'b0);
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            OPC_LOAD: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.reg_write   = 1'b1;
                ctrl.mem_to_reg  = 1'b1;
            end
            OPC_STORE: begin
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
            end
            OPC_BRANCH: begin
                ctrl.branch = (funct3 == F3_BEQ);
            end
            // Anything else retires as a no-operation
            default: ;
        endcase
    end

    // Taken BEQ in execute squashes the two younger instructions
    assign redir.flush = redir.branch_ex & redir.equal_ex;

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
// Instruction fetch stage
`timescale 1ns/1ps
`default_nettype none

module fetch_stage
    import core_pkg::*;
#(
    parameter int IMEM_WORDS = 256
)(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  word_t                         imem_wdata,
    redirect_if.fetch                     redir,
    output word_t                         pc_id,
    output word_t                         instr_id
);

    localparam int IMEM_AW = $clog2(IMEM_WORDS);

    word_t pc;
    word_t instr_if;
    word_t imem [IMEM_WORDS];

    // Program load port
    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_addr] <= imem_wdata;
        end
    end

    // Word addressed with the byte offset dropped
    assign instr_if = imem[pc[IMEM_AW+1:2]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (redir.flush) begin
            pc <= redir.target;
        end else begin
            pc <= pc + 32'd4;
        end
    end

    // IF/ID register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_id    <= '0;
            instr_id <= NOP_INSTR;
        end else if (redir.flush) begin
            pc_id    <= '0;
            instr_id <= NOP_INSTR;
        end else begin
            pc_id    <= pc;
            instr_id <= instr_if;
        end
    end

    // Flush lasts one cycle because it clears the branch in ID/EX
    flush_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) !(redir.flush && $past(redir.flush))
    ) else $error("flush held high for two cycles in a row");

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     instr_id,
    input  word_t     pc_id,
    ctrl_if.stage     ctrl,
    redirect_if.fetch redir,
    input  logic      wb_reg_write,
    input  logic      wb_mem_to_reg,
    input  reg_addr_t wb_rd,
    input  word_t     wb_alu_result,
    input  word_t     wb_load_data,
    input  reg_addr_t dbg_reg_addr,
    output word_t     dbg_reg_data,
    output word_t     pc_ex,
    output word_t     rs1_data_ex,
    output word_t     rs2_data_ex,
    output word_t     imm_ex,
    output reg_addr_t rd_ex,
    output alu_op_e   alu_op_ex,
    output logic      alu_src_imm_ex,
    output logic      mem_read_ex,
    output logic      mem_write_ex,
    output logic      reg_write_ex,
    output logic      mem_to_reg_ex,
    output logic      branch_ex
);

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    word_t     regs [NUM_REGS];
    word_t     wb_data;
    logic      wb_en;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     imm;

    // Writeback select
    assign wb_data = wb_mem_to_reg ? wb_load_data : wb_alu_result;
    // x0 is never written, so it stays at its reset value
    assign wb_en   = wb_reg_write && (wb_rd != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1 = instr_id[RS1_LSB +: REG_ADDR_W];
    assign rs2 = instr_id[RS2_LSB +: REG_ADDR_W];

    // Write-through from writeback in the same cycle
    assign rs1_data = (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

    assign dbg_reg_data = regs[dbg_reg_addr];

    // I-type immediate unless store or branch
    always_comb begin
        case (opcode_e'(instr_id[OPCODE_W-1:0]))
            OPC_STORE:  imm = {{20{instr_id[31]}}, instr_id[31:25], instr_id[11:7]};
            OPC_BRANCH: imm = {{19{instr_id[31]}}, instr_id[31], instr_id[7],
                               instr_id[30:25], instr_id[11:8], 1'b0};
            default:    imm = {{20{instr_id[31]}}, instr_id[31:20]};
        endcase
    end

    // ID/EX controls are squashed on a taken branch
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            alu_op_ex      <= ALU_ADD;
            alu_src_imm_ex <= 1'b0;
            mem_read_ex    <= 1'b0;
            mem_write_ex   <= 1'b0;
            reg_write_ex   <= 1'b0;
            mem_to_reg_ex  <= 1'b0;
            branch_ex      <= 1'b0;
        end else if (redir.flush) begin
            alu_op_ex      <= ALU_ADD;
            alu_src_imm_ex <= 1'b0;
            mem_read_ex    <= 1'b0;
            mem_write_ex   <= 1'b0;
            reg_write_ex   <= 1'b0;
            mem_to_reg_ex  <= 1'b0;
            branch_ex      <= 1'b0;
        end else begin
            alu_op_ex      <= ctrl.alu_op;
            alu_src_imm_ex <= ctrl.alu_src_imm;
            mem_read_ex    <= ctrl.mem_read;
            mem_write_ex   <= ctrl.mem_write;
            reg_write_ex   <= ctrl.reg_write;
            mem_to_reg_ex  <= ctrl.mem_to_reg;
            branch_ex      <= ctrl.branch;
        end
    end

    // ID/EX payload
    always_ff @(posedge clk) begin
        pc_ex       <= pc_id;
        rs1_data_ex <= rs1_data;
        rs2_data_ex <= rs2_data;
        imm_ex      <= imm;
        rd_ex       <= instr_id[RD_LSB +: REG_ADDR_W];
    end

    x0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0)
        else $error("register x0 holds a nonzero value");

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
// Execute stage
`timescale 1ns/1ps
`default_nettype none

module execute_stage
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     pc_ex,
    input  word_t     rs1_data_ex,
    input  word_t     rs2_data_ex,
    input  word_t     imm_ex,
    input  reg_addr_t rd_ex,
    input  alu_op_e   alu_op_ex,
    input  logic      alu_src_imm_ex,
    input  logic      mem_read_ex,
    input  logic      mem_write_ex,
    input  logic      reg_write_ex,
    input  logic      mem_to_reg_ex,
    input  logic      branch_ex,
    redirect_if.ex    redir,
    output word_t     alu_result_mem,
    output word_t     store_data_mem,
    output reg_addr_t rd_mem,
    output logic      mem_read_mem,
    output logic      mem_write_mem,
    output logic      reg_write_mem,
    output logic      mem_to_reg_mem
);

    localparam int SHAMT_W = $clog2(XLEN);

    word_t operand_b;
    word_t alu_result;

    assign operand_b = alu_src_imm_ex ? imm_ex : rs2_data_ex;

    always_comb begin
        case (alu_op_ex)
            ALU_ADD: alu_result = rs1_data_ex + operand_b;
            ALU_SUB: alu_result = rs1_data_ex - operand_b;
            ALU_AND: alu_result = rs1_data_ex & operand_b;
            ALU_OR:  alu_result = rs1_data_ex | operand_b;
            ALU_XOR: alu_result = rs1_data_ex ^ operand_b;
            ALU_SLT: alu_result = {{(XLEN-1){1'b0}}, $signed(rs1_data_ex) < $signed(operand_b)};
            ALU_SLL: alu_result = rs1_data_ex << operand_b[SHAMT_W-1:0];
            ALU_SRL: alu_result = rs1_data_ex >> operand_b[SHAMT_W-1:0];
            default: alu_result = '0;
        endcase
    end

    // BEQ resolves here and redirects fetch
    assign redir.branch_ex = branch_ex;
    assign redir.equal_ex  = (rs1_data_ex == rs2_data_ex);
    assign redir.target    = pc_ex + imm_ex;

    // EX/MEM controls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_read_mem   <= 1'b0;
            mem_write_mem  <= 1'b0;
            reg_write_mem  <= 1'b0;
            mem_to_reg_mem <= 1'b0;
        end else begin
            mem_read_mem   <= mem_read_ex;
            mem_write_mem  <= mem_write_ex;
            reg_write_mem  <= reg_write_ex;
            mem_to_reg_mem <= mem_to_reg_ex;
        end
    end

    // EX/MEM payload
    always_ff @(posedge clk) begin
        alu_result_mem <= alu_result;
        store_data_mem <= rs2_data_ex;
        rd_mem         <= rd_ex;
    end

endmodule

`default_nettype wire

//--- rtl/memory_stage.sv
// Data memory stage
`timescale 1ns/1ps
`default_nettype none

module memory_stage
    import core_pkg::*;
#(
    parameter int DMEM_WORDS = 256
)(
    input  logic      clk,
    input  logic      rst_n,
    input  word_t     alu_result_mem,
    input  word_t     store_data_mem,
    input  reg_addr_t rd_mem,
    input  logic      mem_read_mem,
    input  logic      mem_write_mem,
    input  logic      reg_write_mem,
    input  logic      mem_to_reg_mem,
    output logic      wb_reg_write,
    output logic      wb_mem_to_reg,
    output reg_addr_t wb_rd,
    output word_t     wb_alu_result,
    output word_t     wb_load_data
);

    localparam int DMEM_AW = $clog2(DMEM_WORDS);

    word_t              dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] dmem_addr;
    word_t              load_data;

    // Word address from the ALU result
    assign dmem_addr = alu_result_mem[DMEM_AW+1:2];

    // Cleared at reset so untouched words read as zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= '0;
            end
        end else if (mem_write_mem) begin
            dmem[dmem_addr] <= store_data_mem;
        end
    end

    assign load_data = mem_read_mem ? dmem[dmem_addr] : '0;

    // MEM/WB controls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_reg_write  <= 1'b0;
            wb_mem_to_reg <= 1'b0;
        end else begin
            wb_reg_write  <= reg_write_mem;
            wb_mem_to_reg <= mem_to_reg_mem;
        end
    end

    // MEM/WB payload
    always_ff @(posedge clk) begin
        wb_rd         <= rd_mem;
        wb_alu_result <= alu_result_mem;
        wb_load_data  <= load_data;
    end

    rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n) !(mem_read_mem && mem_write_mem)
    ) else $error("data memory read and write in the same cycle");

endmodule

`default_nettype wire

//--- rtl/core_top.sv
// Five-stage RV32I core
`timescale 1ns/1ps
`default_nettype none

module core_top
    import core_pkg::*;
#(
    parameter int IMEM_WORDS = 256,
    parameter int DMEM_WORDS = 256
)(
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          imem_we,
    input  logic [$clog2(IMEM_WORDS)-1:0] imem_addr,
    input  word_t                         imem_wdata,
    input  reg_addr_t                     dbg_reg_addr,
    output word_t                         dbg_reg_data
);

    // IF/ID
    word_t     pc_id;
    word_t     instr_id;

    // ID/EX
    word_t     pc_ex;
    word_t     rs1_data_ex;
    word_t     rs2_data_ex;
    word_t     imm_ex;
    reg_addr_t rd_ex;
    alu_op_e   alu_op_ex;
    logic      alu_src_imm_ex;
    logic      mem_read_ex;
    logic      mem_write_ex;
    logic      reg_write_ex;
    logic      mem_to_reg_ex;
    logic      branch_ex;

    // EX/MEM
    word_t     alu_result_mem;
    word_t     store_data_mem;
    reg_addr_t rd_mem;
    logic      mem_read_mem;
    logic      mem_write_mem;
    logic      reg_write_mem;
    logic      mem_to_reg_mem;

    // MEM/WB back to the register file
    logic      wb_reg_write;
    logic      wb_mem_to_reg;
    reg_addr_t wb_rd;
    word_t     wb_alu_result;
    word_t     wb_load_data;

    ctrl_if     ctrl_bus ();
    redirect_if redir_bus ();

    main_control u_main_control (
        .instr (instr_id),
        .ctrl  (ctrl_bus),
        .redir (redir_bus)
    );

    fetch_stage #(
        .IMEM_WORDS (IMEM_WORDS)
    ) u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .imem_we    (imem_we),
        .imem_addr  (imem_addr),
        .imem_wdata (imem_wdata),
        .redir      (redir_bus),
        .pc_id      (pc_id),
        .instr_id   (instr_id)
    );

    decode_stage u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr_id       (instr_id),
        .pc_id          (pc_id),
        .ctrl           (ctrl_bus),
        .redir          (redir_bus),
        .wb_reg_write   (wb_reg_write),
        .wb_mem_to_reg  (wb_mem_to_reg),
        .wb_rd          (wb_rd),
        .wb_alu_result  (wb_alu_result),
        .wb_load_data   (wb_load_data),
        .dbg_reg_addr   (dbg_reg_addr),
        .dbg_reg_data   (dbg_reg_data),
        .pc_ex          (pc_ex),
        .rs1_data_ex    (rs1_data_ex),
        .rs2_data_ex    (rs2_data_ex),
        .imm_ex         (imm_ex),
        .rd_ex          (rd_ex),
        .alu_op_ex      (alu_op_ex),
        .alu_src_imm_ex (alu_src_imm_ex),
        .mem_read_ex    (mem_read_ex),
        .mem_write_ex   (mem_write_ex),
        .reg_write_ex   (reg_write_ex),
        .mem_to_reg_ex  (mem_to_reg_ex),
        .branch_ex      (branch_ex)
    );

    execute_stage u_execute (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc_ex          (pc_ex),
        .rs1_data_ex    (rs1_data_ex),
        .rs2_data_ex    (rs2_data_ex),
        .imm_ex         (imm_ex),
        .rd_ex          (rd_ex),
        .alu_op_ex      (alu_op_ex),
        .alu_src_imm_ex (alu_src_imm_ex),
        .mem_read_ex    (mem_read_ex),
        .mem_write_ex   (mem_write_ex),
        .reg_write_ex   (reg_write_ex),
        .mem_to_reg_ex  (mem_to_reg_ex),
        .branch_ex      (branch_ex),
        .redir          (redir_bus),
        .alu_result_mem (alu_result_mem),
        .store_data_mem (store_data_mem),
        .rd_mem         (rd_mem),
        .mem_read_mem   (mem_read_mem),
        .mem_write_mem  (mem_write_mem),
        .reg_write_mem  (reg_write_mem),
        .mem_to_reg_mem (mem_to_reg_mem)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) u_memory (
        .clk            (clk),
        .rst_n          (rst_n),
        .alu_result_mem (alu_result_mem),
        .store_data_mem (store_data_mem),
        .rd_mem         (rd_mem),
        .mem_read_mem   (mem_read_mem),
        .mem_write_mem  (mem_write_mem),
        .reg_write_mem  (reg_write_mem),
        .mem_to_reg_mem (mem_to_reg_mem),
        .wb_reg_write   (wb_reg_write),
        .wb_mem_to_reg  (wb_mem_to_reg),
        .wb_rd          (wb_rd),
        .wb_alu_result  (wb_alu_result),
        .wb_load_data   (wb_load_data)
    );

endmodule

`default_nettype wire

//--- test/tb_core.sv
// Pipelined core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_core;

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 10;
    localparam int IMEM_WORDS   = 256;
    localparam int DMEM_WORDS   = 256;
    localparam int IMEM_AW      = $clog2(IMEM_WORDS);
    localparam int MAX_PROG     = 48;
    localparam int NUM_PROGRAMS = 5;
    // Load, reset, run and register readout of one program
    localparam int PROG_CYCLES  = IMEM_WORDS + RESET_CYCLES + 5 * MAX_PROG + 10 + 32 + 4;
    localparam int WATCHDOG_NS  = NUM_PROGRAMS * PROG_CYCLES * CLK_PERIOD + 2000;

    localparam logic [31:0] NOP_WORD = 32'h0000_0013;
    localparam logic [2:0]  ADD_F3   = 3'b000;
    localparam logic [2:0]  SLL_F3   = 3'b001;
    localparam logic [2:0]  SLT_F3   = 3'b010;
    localparam logic [2:0]  XOR_F3   = 3'b100;
    localparam logic [2:0]  SRL_F3   = 3'b101;
    localparam logic [2:0]  OR_F3    = 3'b110;
    localparam logic [2:0]  AND_F3   = 3'b111;

    logic               clk;
    logic               rst_n;
    logic               imem_we;
    logic [IMEM_AW-1:0] imem_addr;
    logic [31:0]        imem_wdata;
    logic [4:0]         dbg_reg_addr;
    logic [31:0]        dbg_reg_data;

    // Program image and the reference model state
    logic [31:0] prog [$];
    logic [31:0] m_reg [32];
    logic [31:0] m_mem [DMEM_WORDS];
    int          skip_count;
    logic [31:0] lcg_state = 32'd38765;
    int          checks = 0;
    int          errors = 0;

    core_top #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .imem_we      (imem_we),
        .imem_addr    (imem_addr),
        .imem_wdata   (imem_wdata),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Upper bits of the LCG are the better ones
    function automatic logic [11:0] rand_imm();
        logic [31:0] r;
        r = next_random();
        return r[27:16];
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // ISA result of an ALU op
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic sub,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            ADD_F3:  return sub ? a - b : a + b;
            SLL_F3:  return a << b[4:0];
            SLT_F3:  return {31'b0, $signed(a) < $signed(b)};
            XOR_F3:  return a ^ b;
            SRL_F3:  return a >> b[4:0];
            OR_F3:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic clear_model();
        prog.delete();
        skip_count = 0;
        for (int i = 0; i < 32; i++) begin
            m_reg[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            m_mem[i] = '0;
        end
    endtask

    // Retire goes low for words in the slots squashed by a taken branch
    task automatic append(input logic [31:0] w, output bit retire);
        prog.push_back(w);
        retire = (skip_count == 0);
        if (skip_count > 0) begin
            skip_count--;
        end
    endtask

    task automatic write_reg(input logic [4:0] rd, input logic [31:0] value);
        if (rd != 5'd0) begin
            m_reg[rd] = value;
        end
    endtask

    task automatic add_nops(input int n);
        bit retire;
        for (int i = 0; i < n; i++) begin
            append(NOP_WORD, retire);
        end
    endtask

    task automatic alu_imm(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                           input logic [11:0] imm);
        bit retire;
        append({imm, rs1, f3, rd, 7'b0010011}, retire);
        if (retire) begin
            write_reg(rd, alu_ref(f3, 1'b0, m_reg[rs1], sext12(imm)));
        end
    endtask

    task automatic alu_reg(input logic [2:0] f3, input logic sub, input logic [4:0] rd,
                           input logic [4:0] rs1, input logic [4:0] rs2);
        bit retire;
        append({sub ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, 7'b0110011}, retire);
        if (retire) begin
            write_reg(rd, alu_ref(f3, sub, m_reg[rs1], m_reg[rs2]));
        end
    endtask

    task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                              input logic [11:0] imm);
        bit          retire;
        logic [31:0] addr;
        append({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011}, retire);
        addr = m_reg[rs1] + sext12(imm);
        if (retire) begin
            m_mem[addr[9:2]] = m_reg[rs2];
        end
    endtask

    task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1,
                             input logic [11:0] imm);
        bit          retire;
        logic [31:0] addr;
        append({imm, rs1, 3'b010, rd, 7'b0000011}, retire);
        addr = m_reg[rs1] + sext12(imm);
        if (retire) begin
            write_reg(rd, m_mem[addr[9:2]]);
        end
    endtask

    // BEQ with offset 12, so a taken branch lands three slots on
    task automatic branch_eq(input logic [4:0] rs1, input logic [4:0] rs2);
        bit retire;
        append({1'b0, 6'd0, rs2, rs1, 3'b000, 4'b0110, 1'b0, 7'b1100011}, retire);
        if (retire && m_reg[rs1] == m_reg[rs2]) begin
            skip_count = 2;
        end
    endtask

    // Reset stays low through the load and ten cycles after it
    task automatic load_program();
        @(posedge clk);
        rst_n <= 1'b0;
        for (int i = 0; i < IMEM_WORDS; i++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= IMEM_AW'(i);
            imem_wdata <= (i < prog.size()) ? prog[i] : NOP_WORD;
        end
        @(posedge clk);
        imem_we <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic run_and_check(input string name);
        if (prog.size() > MAX_PROG) begin
            errors++;
            $display("%s: program of %0d words is longer than the limit", name, prog.size());
        end
        load_program();
        repeat (5 * prog.size() + 10) @(posedge clk);
        for (int r = 0; r < 32; r++) begin
            @(posedge clk);
            dbg_reg_addr <= 5'(r);
            @(negedge clk);
            check_value($sformatf("%s x%0d", name, r), m_reg[r], dbg_reg_data);
        end
    endtask

    task automatic reset_state_test();
        bit retire;
        clear_model();
        add_nops(6);
        alu_imm(ADD_F3, 5'd0, 5'd0, 12'h123);
        add_nops(2);
        alu_reg(ADD_F3, 1'b0, 5'd0, 5'd0, 5'd0);
        // Unknown opcode with rd of x1
        append({12'h055, 5'd0, 3'b000, 5'd1, 7'b1111111}, retire);
        add_nops(4);
        run_and_check("reset");
    endtask

    task automatic imm_ops_test();
        clear_model();
        alu_imm(ADD_F3, 5'd1, 5'd0, rand_imm() & 12'h7ff);
        alu_imm(ADD_F3, 5'd2, 5'd0, rand_imm() | 12'h800);
        add_nops(2);
        alu_imm(ADD_F3, 5'd3, 5'd1, rand_imm());
        alu_imm(SLT_F3, 5'd4, 5'd2, rand_imm());
        alu_imm(AND_F3, 5'd5, 5'd1, rand_imm());
        alu_imm(OR_F3,  5'd6, 5'd2, rand_imm());
        alu_imm(XOR_F3, 5'd7, 5'd1, rand_imm());
        alu_imm(SLL_F3, 5'd8, 5'd1, rand_imm() & 12'h01f);
        alu_imm(SRL_F3, 5'd9, 5'd2, rand_imm() & 12'h01f);
        add_nops(2);
        run_and_check("alu_imm");
    endtask

    task automatic reg_ops_test();
        clear_model();
        alu_imm(ADD_F3, 5'd1, 5'd0, rand_imm() & 12'h7ff);
        alu_imm(ADD_F3, 5'd2, 5'd0, rand_imm() | 12'h800);
        alu_imm(ADD_F3, 5'd3, 5'd0, (rand_imm() & 12'h00f) | 12'h001);
        add_nops(2);
        alu_reg(ADD_F3, 1'b0, 5'd4, 5'd1, 5'd2);
        alu_reg(ADD_F3, 1'b1, 5'd5, 5'd1, 5'd2);
        alu_reg(AND_F3, 1'b0, 5'd6, 5'd1, 5'd2);
        alu_reg(OR_F3,  1'b0, 5'd7, 5'd1, 5'd2);
        alu_reg(XOR_F3, 1'b0, 5'd8, 5'd1, 5'd2);
        // Negative against positive both ways round
        alu_reg(SLT_F3, 1'b0, 5'd9, 5'd2, 5'd1);
        alu_reg(SLT_F3, 1'b0, 5'd10, 5'd1, 5'd2);
        alu_reg(SLL_F3, 1'b0, 5'd11, 5'd1, 5'd3);
        alu_reg(SRL_F3, 1'b0, 5'd12, 5'd2, 5'd3);
        add_nops(2);
        // Minimum padding where decode reads the value being written back
        alu_reg(ADD_F3, 1'b1, 5'd13, 5'd4, 5'd12);
        add_nops(2);
        alu_reg(ADD_F3, 1'b0, 5'd14, 5'd13, 5'd1);
        add_nops(2);
        run_and_check("alu_reg");
    endtask

    task automatic memory_test();
        clear_model();
        alu_imm(ADD_F3, 5'd1, 5'd0, rand_imm());
        alu_imm(ADD_F3, 5'd2, 5'd0, rand_imm() & 12'h0f0);
        alu_imm(ADD_F3, 5'd5, 5'd0, rand_imm());
        add_nops(2);
        store_word(5'd1, 5'd2, 12'd8);
        load_word(5'd3, 5'd2, 12'd8);
        // Next word was never stored
        load_word(5'd5, 5'd2, 12'd12);
        add_nops(2);
        store_word(5'd3, 5'd2, 12'd20);
        load_word(5'd4, 5'd2, 12'd20);
        add_nops(2);
        run_and_check("memory");
    endtask

    task automatic branch_test();
        logic [11:0] v;
        clear_model();
        v = rand_imm();
        alu_imm(ADD_F3, 5'd1, 5'd0, v);
        alu_imm(ADD_F3, 5'd2, 5'd0, v);
        alu_imm(ADD_F3, 5'd3, 5'd0, v ^ 12'h001);
        alu_imm(ADD_F3, 5'd10, 5'd0, rand_imm());
        add_nops(2);
        branch_eq(5'd1, 5'd2);
        alu_imm(ADD_F3, 5'd10, 5'd0, rand_imm());
        alu_imm(ADD_F3, 5'd11, 5'd0, rand_imm());
        alu_imm(ADD_F3, 5'd12, 5'd0, rand_imm());
        add_nops(2);
        branch_eq(5'd1, 5'd3);
        alu_imm(ADD_F3, 5'd13, 5'd0, rand_imm());
        alu_imm(ADD_F3, 5'd14, 5'd0, rand_imm());
        alu_imm(ADD_F3, 5'd15, 5'd0, rand_imm());
        add_nops(2);
        run_and_check("branch");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Test failures found");
        $finish;
    end

    initial begin
        rst_n        = 1'b0;
        imem_we      = 1'b0;
        imem_addr    = '0;
        imem_wdata   = '0;
        dbg_reg_addr = '0;
        reset_state_test();
        imm_ops_test();
        reg_ops_test();
        memory_test();
        branch_test();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/core_pkg.sv
rtl/core_ifs.sv
rtl/main_control.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/core_top.sv
test/tb_core.sv

//--- Makefile
TOOL  := verilator
FLAGS := --binary --timing --assert -j 0
TOP   := tb_core
FLIST := flist.f
BUILD := obj_dir
LOG   := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
